// ==== Bender.yml ====
package:
  name: lsu_pipe

sources:
  - src/lsu_pkg.sv
  - src/mem_req_if.sv
  - src/mem_access_stage.sv
  - src/data_ram.sv
  - src/load_align_stage.sv
  - src/lsu_pipe.sv
  - target: test
    files:
      - testbench/lsu_pipe_tb.sv

// ==== lsu_pipe.f ====
src/lsu_pkg.sv
src/mem_req_if.sv
src/mem_access_stage.sv
src/data_ram.sv
src/load_align_stage.sv
src/lsu_pipe.sv
testbench/lsu_pipe_tb.sv

// ==== src/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_W = 8
) (
    input  logic        clk,
    mem_req_if.memory   mem,
    output logic [31:0] rdata_o
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [31:0] ram [DEPTH];

    // lane 3 is the byte at offset 0
    always_ff @(posedge clk) begin
        if (mem.ce && mem.we) begin
            for (int i = 0; i < 4; i++) begin
                if (mem.sel[i]) begin
                    ram[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (mem.ce && !mem.we) begin
            rdata_o <= ram[mem.addr];
        end
    end

    a_write_has_lanes: assert property (@(posedge clk)
        mem.ce && mem.we |-> mem.sel != 4'b0000);

endmodule

// ==== src/load_align_stage.sv ====
`timescale 1ns/1ps

module load_align_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  lsu_pkg::lane_info_t info_i,
    input  logic [31:0]         rdata_i,
    output logic                wb_valid_o,
    output logic                wb_we_o,
    output logic [4:0]          wb_waddr_o,
    output logic [31:0]         wb_wdata_o,
    output logic                excp_o,
    output lsu_pkg::excp_code_t excp_code_o
);
    import lsu_pkg::*;

    lane_info_t  info_q;
    logic [7:0]  byte_data;
    logic [15:0] half_data;
    logic [31:0] result;

    // line up with the registered RAM read
    always_ff @(posedge clk) begin
        if (rst_i) begin
            info_q <= '0;
        end else begin
            info_q <= info_i;
        end
    end

    always_comb begin
        case (info_q.offset)
            2'd0: byte_data = rdata_i[31:24];
            2'd1: byte_data = rdata_i[23:16];
            2'd2: byte_data = rdata_i[15:8];
            default: byte_data = rdata_i[7:0];
        endcase
        half_data = info_q.offset[1] ? rdata_i[15:0] : rdata_i[31:16];
    end

    always_comb begin
        case (info_q.op)
            op_ld_b:         result = {{24{byte_data[7]}}, byte_data};
            op_ld_bu:        result = {24'b0, byte_data};
            op_ld_h:         result = {{16{half_data[15]}}, half_data};
            op_ld_hu:        result = {16'b0, half_data};
            op_ld_w, op_ll:  result = rdata_i;
            // sc reports success as 1 or 0
            op_sc:           result = {31'b0, info_q.sc_ok};
            default:         result = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o  <= 1'b0;
            wb_we_o     <= 1'b0;
            excp_o      <= 1'b0;
            excp_code_o <= '0;
        end else begin
            wb_valid_o  <= info_q.valid;
            wb_we_o     <= info_q.wreg;
            excp_o      <= info_q.excp;
            excp_code_o <= info_q.code;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr_o <= info_q.waddr;
        wb_wdata_o <= info_q.wreg ? result : 32'b0;
    end

    // wreg is cleared upstream on any exception
    a_no_write_on_excp: assert property (@(posedge clk) disable iff (rst_i)
        !(wb_we_o && excp_o));

endmodule

// ==== src/lsu_pipe.sv ====
`timescale 1ns/1ps

module lsu_pipe #(
    parameter int ADDR_W = 8
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        valid_i,
    input  logic [3:0]  op_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] reg2_i,
    input  logic [4:0]  waddr_i,
    input  logic [1:0]  csr_plv_i,
    input  logic        csr_da_i,
    input  logic        csr_pg_i,
    input  logic [4:0]  csr_dmw0_i,
    input  logic [4:0]  csr_dmw1_i,
    input  logic        tlb_found_i,
    input  logic        tlb_v_i,
    input  logic        tlb_d_i,
    input  logic [1:0]  tlb_plv_i,
    output logic        wb_valid_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_waddr_o,
    output logic [31:0] wb_wdata_o,
    output logic        excp_o,
    output logic [5:0]  excp_code_o
);
    import lsu_pkg::*;

    csr_mode_t   csr;
    tlb_result_t tlb;
    lane_info_t  info;
    logic [31:0] rdata;

    mem_req_if #(.ADDR_W(ADDR_W)) mem_req ();

    // window fields are plv0, plv3, vseg from high bit down
    always_comb begin
        csr.plv   = csr_plv_i;
        csr.da    = csr_da_i;
        csr.pg    = csr_pg_i;
        csr.dmw0  = csr_dmw0_i;
        csr.dmw1  = csr_dmw1_i;
        tlb.found = tlb_found_i;
        tlb.v     = tlb_v_i;
        tlb.d     = tlb_d_i;
        tlb.plv   = tlb_plv_i;
    end

    mem_access_stage #(
        .ADDR_W(ADDR_W)
    ) u_access (
        .clk    (clk),
        .rst_i  (rst_i),
        .valid_i(valid_i),
        .op_i   (lsu_op_e'(op_i)),
        .addr_i (addr_i),
        .reg2_i (reg2_i),
        .waddr_i(waddr_i),
        .csr_i  (csr),
        .tlb_i  (tlb),
        .req    (mem_req.requester),
        .info_o (info)
    );

    data_ram #(
        .ADDR_W(ADDR_W)
    ) u_ram (
        .clk    (clk),
        .mem    (mem_req.memory),
        .rdata_o(rdata)
    );

    load_align_stage u_align (
        .clk        (clk),
        .rst_i      (rst_i),
        .info_i     (info),
        .rdata_i    (rdata),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_wdata_o (wb_wdata_o),
        .excp_o     (excp_o),
        .excp_code_o(excp_code_o)
    );

endmodule

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // memory operations issued by the execute side
    typedef enum logic [3:0] {
        op_none  = 4'd0,
        op_ld_b  = 4'd1,
        op_ld_bu = 4'd2,
        op_ld_h  = 4'd3,
        op_ld_hu = 4'd4,
        op_ld_w  = 4'd5,
        op_st_b  = 4'd6,
        op_st_h  = 4'd7,
        op_st_w  = 4'd8,
        op_ll    = 4'd9,
        op_sc    = 4'd10
    } lsu_op_e;

    // exception code, pil in the top bit down to adem in bit 0
    typedef logic [5:0] excp_code_t;

    localparam int EXCP_PIL  = 5;
    localparam int EXCP_PIS  = 4;
    localparam int EXCP_PPI  = 3;
    localparam int EXCP_PME  = 2;
    localparam int EXCP_TLBR = 1;
    localparam int EXCP_ADEM = 0;

    // one direct map window
    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic [1:0] plv;
        logic       da;
        logic       pg;
        dmw_t       dmw0;
        dmw_t       dmw1;
    } csr_mode_t;

    typedef struct packed {
        logic       found;
        logic       v;
        logic       d;
        logic [1:0] plv;
    } tlb_result_t;

    // what the align stage needs to finish an access
    typedef struct packed {
        logic       valid;
        lsu_op_e    op;
        logic [1:0] offset;
        logic [4:0] waddr;
        logic       wreg;
        logic       excp;
        excp_code_t code;
        logic       sc_ok;
    } lane_info_t;

endpackage

// ==== src/mem_access_stage.sv ====
`timescale 1ns/1ps

module mem_access_stage #(
    parameter int ADDR_W = 8
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  lsu_pkg::lsu_op_e     op_i,
    input  logic [31:0]          addr_i,
    input  logic [31:0]          reg2_i,
    input  logic [4:0]           waddr_i,
    input  lsu_pkg::csr_mode_t   csr_i,
    input  lsu_pkg::tlb_result_t tlb_i,
    mem_req_if.requester         req,
    output lsu_pkg::lane_info_t  info_o
);
    import lsu_pkg::*;

    logic        is_load;
    logic        is_store;
    logic        is_half;
    logic        is_word;
    logic        access;
    logic [1:0]  offset;
    logic [3:0]  sel;
    logic [31:0] wdata;
    logic        trans_en;
    excp_code_t  code;
    logic        excp;
    logic        link_q;
    logic        sc_pass;
    logic        ce_d;
    lane_info_t  info_d;

    function automatic logic dmw_hit(input dmw_t dmw, input logic [1:0] plv,
                                     input logic [2:0] vseg);
        return ((dmw.plv0 && plv == 2'd0) || (dmw.plv3 && plv == 2'd3)) && (vseg == dmw.vseg);
    endfunction

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (op_i)
            op_ld_b, op_ld_bu: begin
                is_load = 1'b1;
            end
            op_ld_h, op_ld_hu: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            op_ld_w, op_ll: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            op_st_b: begin
                is_store = 1'b1;
            end
            op_st_h: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            op_st_w, op_sc: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign access = valid_i && (is_load || is_store);
    assign offset = addr_i[1:0];

    // offset 0 lives in lane 3
    always_comb begin
        if (is_word) begin
            sel   = 4'b1111;
            wdata = reg2_i;
        end else if (is_half) begin
            sel   = offset[1] ? 4'b0011 : 4'b1100;
            wdata = {2{reg2_i[15:0]}};
        end else begin
            sel   = 4'b1000 >> offset;
            wdata = {4{reg2_i[7:0]}};
        end
    end

    // translate only in paging mode outside both windows
    assign trans_en = csr_i.pg && !csr_i.da
                      && !dmw_hit(csr_i.dmw0, csr_i.plv, addr_i[31:29])
                      && !dmw_hit(csr_i.dmw1, csr_i.plv, addr_i[31:29]);

    always_comb begin
        code            = '0;
        code[EXCP_ADEM] = access && ((is_half && offset[0]) || (is_word && offset != 2'b00));
        code[EXCP_TLBR] = access && trans_en && !tlb_i.found;
        code[EXCP_PIL]  = access && trans_en && is_load && !tlb_i.v;
        code[EXCP_PIS]  = access && trans_en && is_store && !tlb_i.v;
        code[EXCP_PPI]  = access && trans_en && tlb_i.v && (csr_i.plv > tlb_i.plv);
        code[EXCP_PME]  = access && trans_en && is_store && tlb_i.v
                          && (csr_i.plv <= tlb_i.plv) && !tlb_i.d;
    end

    assign excp    = |code;
    assign sc_pass = access && !excp && (op_i == op_sc) && link_q;
    // an sc without the link bit never reaches the RAM
    assign ce_d    = access && !excp && ((op_i != op_sc) || link_q);

    always_comb begin
        info_d        = '0;
        info_d.valid  = access;
        info_d.op     = op_i;
        info_d.offset = offset;
        info_d.waddr  = waddr_i;
        info_d.wreg   = access && !excp && (is_load || op_i == op_sc);
        info_d.excp   = excp;
        info_d.code   = code;
        info_d.sc_ok  = sc_pass;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req.ce  <= 1'b0;
            req.we  <= 1'b0;
            req.sel <= 4'b0000;
            info_o  <= '0;
            link_q  <= 1'b0;
        end else begin
            req.ce  <= ce_d;
            req.we  <= ce_d && is_store;
            req.sel <= ce_d ? sel : 4'b0000;
            info_o  <= info_d;
            if (access && !excp && op_i == op_ll) begin
                link_q <= 1'b1;
            end else if (sc_pass) begin
                link_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        req.addr  <= addr_i[ADDR_W+1:2];
        req.wdata <= wdata;
    end

    a_sel_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        req.ce |-> req.sel != 4'b0000);

    a_sc_ok_only_sc: assert property (@(posedge clk) disable iff (rst_i)
        info_o.sc_ok |-> info_o.op == op_sc);

endmodule

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if #(
    parameter int ADDR_W = 8
);

    logic              ce;
    logic              we;
    logic [3:0]        sel;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;

    // access stage side
    modport requester (
        output ce,
        output we,
        output sel,
        output addr,
        output wdata
    );

    // data ram side
    modport memory (
        input ce,
        input we,
        input sel,
        input addr,
        input wdata
    );

endinterface

// ==== testbench/lsu_cases.txt ====
# gap op addr data waddr | csr: plv da pg dmw0 dmw1 | tlb: found v d plv | exp: we wdata code
# all hex; gap is the most idle cycles before the case, code bits pil pis ppi pme tlbr adem
0 8 00000010 11223344 01 0 1 0 00 00 0 0 0 0 0 00000000 00
0 5 00000010 00000000 02 0 1 0 00 00 0 0 0 0 1 11223344 00
0 1 00000010 00000000 03 0 1 0 00 00 0 0 0 0 1 00000011 00
0 1 00000013 00000000 04 0 1 0 00 00 0 0 0 0 1 00000044 00
0 6 00000011 000000f0 05 0 1 0 00 00 0 0 0 0 0 00000000 00
0 1 00000011 00000000 06 0 1 0 00 00 0 0 0 0 1 fffffff0 00
0 2 00000011 00000000 07 0 1 0 00 00 0 0 0 0 1 000000f0 00
0 7 00000012 00008899 08 0 1 0 00 00 0 0 0 0 0 00000000 00
0 3 00000012 00000000 09 0 1 0 00 00 0 0 0 0 1 ffff8899 00
0 4 00000012 00000000 0a 0 1 0 00 00 0 0 0 0 1 00008899 00
0 3 00000010 00000000 0b 0 1 0 00 00 0 0 0 0 1 000011f0 00
0 2 00000012 00000000 0c 0 1 0 00 00 0 0 0 0 1 00000088 00
1 2 00000013 00000000 0d 0 1 0 00 00 0 0 0 0 1 00000099 00
1 7 00000013 0000aaaa 0e 0 1 0 00 00 0 0 0 0 0 00000000 01
1 8 00000012 deadbeef 0f 0 1 0 00 00 0 0 0 0 0 00000000 01
1 5 00000011 00000000 10 0 1 0 00 00 0 0 0 0 0 00000000 01
1 5 00000010 00000000 11 0 1 0 00 00 0 0 0 0 1 11f08899 00
1 5 00000010 00000000 12 3 0 1 00 00 0 1 1 3 0 00000000 02
1 5 00000010 00000000 13 3 0 1 00 00 1 0 1 3 0 00000000 20
1 8 00000010 77777777 14 3 0 1 00 00 1 0 1 3 0 00000000 10
1 5 00000010 00000000 15 3 0 1 00 00 1 1 1 0 0 00000000 08
1 8 00000010 77777777 16 3 0 1 00 00 1 1 0 3 0 00000000 04
1 5 00000010 00000000 17 3 0 1 00 00 1 1 1 3 1 11f08899 00
1 5 00000010 00000000 18 3 0 1 10 00 0 1 1 3 0 00000000 02
1 5 00000010 00000000 19 3 0 1 08 00 0 0 0 0 1 11f08899 00
1 8 00000010 55667788 1a 0 0 1 00 10 0 0 0 0 0 00000000 00
1 5 00000010 00000000 1b 3 1 1 00 00 0 0 0 0 1 55667788 00
1 8 00000030 cafef00d 1c 0 1 0 00 00 0 0 0 0 0 00000000 00
1 9 00000030 00000000 1d 0 1 0 00 00 0 0 0 0 1 cafef00d 00
1 a 00000030 12345678 1e 0 1 0 00 00 0 0 0 0 1 00000001 00
1 a 00000030 0badf00d 1f 0 1 0 00 00 0 0 0 0 1 00000000 00
0 5 00000030 00000000 01 0 1 0 00 00 0 0 0 0 1 12345678 00

// ==== testbench/lsu_pipe_tb.sv ====
`timescale 1ns/1ps

module lsu_pipe_tb;

    localparam int RESET_CYCLES = 16;

    typedef struct {
        int          gap;
        logic [3:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [4:0]  waddr;
        logic [1:0]  plv;
        logic        da;
        logic        pg;
        logic [4:0]  dmw0;
        logic [4:0]  dmw1;
        logic        found;
        logic        v;
        logic        d;
        logic [1:0]  tplv;
        logic        exp_we;
        logic [31:0] exp_wdata;
        logic [5:0]  exp_code;
    } case_t;

    // case index and the cycle its result is due
    typedef struct {
        int idx;
        int due;
    } pending_t;

    logic        clk, rst_i, valid_i;
    logic [3:0]  op_i;
    logic [31:0] addr_i, reg2_i;
    logic [4:0]  waddr_i, csr_dmw0_i, csr_dmw1_i;
    logic [1:0]  csr_plv_i, tlb_plv_i;
    logic        csr_da_i, csr_pg_i, tlb_found_i, tlb_v_i, tlb_d_i;
    logic        wb_valid_o, wb_we_o, excp_o;
    logic [4:0]  wb_waddr_o;
    logic [31:0] wb_wdata_o;
    logic [5:0]  excp_code_o;

    case_t    cases[$];
    pending_t pend[$];
    int       cycle = 0;
    int       limit = 0;
    int       errors = 0;
    int       checked = 0;
    int       seed;
    int       idle;

    lsu_pipe #(.ADDR_W(8)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        case_t c;
        fd = $fopen("testbench/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/lsu_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                c.gap, c.op, c.addr, c.data, c.waddr, c.plv, c.da, c.pg,
                                c.dmw0, c.dmw1, c.found, c.v, c.d, c.tplv,
                                c.exp_we, c.exp_wdata, c.exp_code);
                    if (n == 17) begin
                        cases.push_back(c);
                    end else if (n > 0) begin
                        $display("malformed line in case file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_case(input case_t c);
        valid_i     <= 1'b1;
        op_i        <= c.op;
        addr_i      <= c.addr;
        reg2_i      <= c.data;
        waddr_i     <= c.waddr;
        csr_plv_i   <= c.plv;
        csr_da_i    <= c.da;
        csr_pg_i    <= c.pg;
        csr_dmw0_i  <= c.dmw0;
        csr_dmw1_i  <= c.dmw1;
        tlb_found_i <= c.found;
        tlb_v_i     <= c.v;
        tlb_d_i     <= c.d;
        tlb_plv_i   <= c.tplv;
    endtask

    task automatic drive_idle();
        valid_i <= 1'b0;
        op_i    <= 4'd0;
    endtask

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] got, inout int bad);
        assert (got === exp) else begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            bad++;
        end
    endtask

    task automatic check_result(input pending_t p);
        case_t c;
        int    bad;
        c   = cases[p.idx];
        bad = 0;
        assert (cycle == p.due) else begin
            $display("case %0d finished at cycle %0d instead of %0d", p.idx, cycle, p.due);
            bad++;
        end
        compare("wb_we_o", c.exp_we, wb_we_o, bad);
        compare("wb_wdata_o", c.exp_wdata, wb_wdata_o, bad);
        compare("wb_waddr_o", c.waddr, wb_waddr_o, bad);
        compare("excp_code_o", c.exp_code, excp_code_o, bad);
        compare("excp_o", c.exp_code != 6'd0, excp_o, bad);
        checked++;
        errors += bad;
        $display("case %0d op %h addr %h: %s", p.idx, c.op, c.addr,
                 (bad == 0) ? "pass" : "mismatch");
    endtask

    // outputs are sampled half a cycle after the edge that sets them
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout after %0d cycles, %0d results missing", cycle, pend.size());
            $display("ERRORS FOUND");
            $finish;
        end else if (!rst_i && wb_valid_o) begin
            if (pend.size() == 0) begin
                $display("writeback seen with no case in flight");
                errors++;
            end else begin
                check_result(pend.pop_front());
            end
        end else if (pend.size() > 0 && pend[0].due <= cycle) begin
            $display("case %0d gave no writeback by cycle %0d", pend[0].idx, cycle);
            errors++;
            void'(pend.pop_front());
        end
    end

    initial begin
        seed        = 32'h34ff;
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        op_i        = 4'd0;
        addr_i      = 32'd0;
        reg2_i      = 32'd0;
        waddr_i     = 5'd0;
        csr_plv_i   = 2'd0;
        csr_da_i    = 1'b1;
        csr_pg_i    = 1'b0;
        csr_dmw0_i  = 5'd0;
        csr_dmw1_i  = 5'd0;
        tlb_found_i = 1'b0;
        tlb_v_i     = 1'b0;
        tlb_d_i     = 1'b0;
        tlb_plv_i   = 2'd0;
        read_cases();
        limit = 2 * cases.size() + RESET_CYCLES + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        foreach (cases[i]) begin
            idle = 0;
            if (cases[i].gap > 0) begin
                idle = $unsigned($random(seed)) % (cases[i].gap + 1);
            end
            repeat (idle) begin
                @(posedge clk);
                drive_idle();
            end
            @(posedge clk);
            drive_case(cases[i]);
            // captured one edge later, then two cycles through the pipe
            pend.push_back('{i, cycle + 4});
        end
        @(posedge clk);
        drive_idle();
        while (pend.size() > 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("%0d cases, %0d checked, %0d errors", cases.size(), checked, errors);
        if (errors == 0 && cases.size() > 0 && checked == cases.size()) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
